//--- hw/cfg_reg_pkg.sv
package cfg_reg_pkg;

  // Bus address width
  localparam int ADDR_W = 32;

  // Bitline data shift register
  localparam logic [31:0] BL_DATA_SHIFT_ADDR = 32'h0000_001e;

  // Enable setup field is narrower than the other phases
  localparam int T_SUBL_W  = 3;
  localparam int T_PHASE_W = 8;

  // Checksum command
  typedef enum logic [1:0] {
    CMD_NONE = 2'd0,
    CMD_PRE  = 2'd1,
    CMD_POST = 2'd2,
    CMD_RSVD = 2'd3
  } cfg_cmd_e;

endpackage

//--- hw/cfg_seq_pkg.sv
package cfg_seq_pkg;

  // Write sequencer states, in order of one line write
  typedef enum logic [2:0] {
    WR_IDLE    = 3'd0,
    WR_WLCLK   = 3'd1,
    WR_SUBLWEN = 3'd2,
    WR_WSU     = 3'd3,
    WR_WRITE   = 3'd4,
    WR_WHD     = 3'd5
  } write_state_e;

  // Shared phase timer, wide enough for any timing field
  localparam int PHASE_CNT_W = 8;

endpackage

//--- hw/bl_shift_decode.sv
`timescale 1ns/1ns

module bl_shift_decode (
  input  logic                           FCB_CLK,
  input  logic                           fcb_reg_rstn,
  input  logic                           apb_penable,
  input  logic                           apb_pwrite,
  input  logic [cfg_reg_pkg::ADDR_W-1:0] apb_paddr,
  input  logic                           kickoff,
  input  logic                           mask_write,
  output logic                           shift_wr,
  output logic                           bl_clk,
  output logic                           prechksum_w0,
  output logic                           prechksum_w1
);

  logic addr_hit;

  assign addr_hit = (apb_paddr == cfg_reg_pkg::BL_DATA_SHIFT_ADDR);

  // Writes are dropped while a row is being committed
  assign shift_wr = apb_penable & apb_pwrite & addr_hit & ~mask_write;

  // One BL_CLK pulse per accepted bitline
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      bl_clk <= 1'b0;
    end else begin
      bl_clk <= shift_wr & kickoff;
    end
  end

  // Checksum capture of word 0 then word 1 a cycle later
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      prechksum_w0 <= 1'b0;
      prechksum_w1 <= 1'b0;
    end else begin
      prechksum_w0 <= shift_wr;
      prechksum_w1 <= prechksum_w0;
    end
  end

endmodule

//--- hw/line_counter.sv
`timescale 1ns/1ns

module line_counter #(
  parameter int CNT_W = 32
) (
  input  logic                  FCB_CLK,
  input  logic                  fcb_reg_rstn,
  input  logic                  shift_wr,
  input  logic                  apb_penable,
  input  logic                  kickoff,
  input  logic                  wl_clk,
  input  logic                  write_done,
  input  cfg_reg_pkg::cfg_cmd_e cmd,
  input  logic [CNT_W-1:0]      bl_max_length,
  input  logic [CNT_W-1:0]      wl_max_length,
  output logic                  bl_full,
  output logic                  wl_last,
  output logic                  wl_first,
  output logic                  mask_write,
  output logic                  cfg_done
);

  logic [CNT_W-1:0] bl_cnt;
  logic [CNT_W-1:0] wl_cnt;
  logic [CNT_W-1:0] bl_end;
  logic [CNT_W-1:0] wl_end;
  logic             cmd_done_ok;

  assign bl_end = bl_max_length + 1'b1;
  assign wl_end = wl_max_length + 1'b1;

  // A wrapped row length never counts as full
  assign bl_full  = (bl_cnt == bl_end) && (bl_cnt != '0);
  assign wl_last  = (wl_cnt == wl_end);
  assign wl_first = (wl_cnt == '0);

  // Bitlines of the current row
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      bl_cnt <= '0;
    end else if (write_done) begin
      bl_cnt <= '0;
    end else if (shift_wr) begin
      bl_cnt <= bl_cnt + 1'b1;
    end
  end

  // Wordlines of the current frame
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      wl_cnt <= '0;
    end else if (write_done && wl_last) begin
      wl_cnt <= '0;
    end else if (wl_clk) begin
      wl_cnt <= wl_cnt + 1'b1;
    end
  end

  // Any bus cycle on the last bitline closes the row to the host
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      mask_write <= 1'b0;
    end else if (write_done) begin
      mask_write <= 1'b0;
    end else if ((bl_cnt == bl_max_length) && apb_penable && kickoff) begin
      mask_write <= 1'b1;
    end
  end

  // Post checksum frames never finish here
  assign cmd_done_ok = (cmd == cfg_reg_pkg::CMD_NONE) || (cmd == cfg_reg_pkg::CMD_PRE);

  assign cfg_done = write_done & bl_full & wl_last & cmd_done_ok;

endmodule

//--- hw/write_timing_fsm.sv
`timescale 1ns/1ns

module write_timing_fsm #(
  parameter int CNT_W = 32
) (
  input  logic                            FCB_CLK,
  input  logic                            fcb_reg_rstn,
  input  logic                            kickoff,
  input  logic                            bl_full,
  input  logic                            wl_first,
  input  logic [cfg_reg_pkg::T_SUBL_W-1:0]  t_sublwen,
  input  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_wsu,
  input  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_write,
  input  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_whd,
  input  logic [31:0]                     wl_data_shift,
  output logic                            wl_clk,
  output logic                            blwen,
  output logic                            wlwen,
  output logic                            write_done,
  output logic [31:0]                     ctrl_head
);

  localparam int PW = cfg_seq_pkg::PHASE_CNT_W;

  cfg_seq_pkg::write_state_e state;
  cfg_seq_pkg::write_state_e state_nxt;
  logic [PW-1:0]             phase_cnt;
  logic [PW-1:0]             phase_lim;
  logic                      phase_end;
  logic                      line_start;

  // Timer has to reach every timing field and counters need a bit
  if (CNT_W < 1 || PW < cfg_reg_pkg::T_PHASE_W || PW < cfg_reg_pkg::T_SUBL_W) begin : g_width_chk
    $error("write_timing_fsm: counter widths too narrow");
  end

  // Limit of the running phase is zero when untimed
  always_comb begin
    case (state)
      cfg_seq_pkg::WR_SUBLWEN: phase_lim = PW'(t_sublwen);
      cfg_seq_pkg::WR_WSU:     phase_lim = PW'(t_wsu);
      cfg_seq_pkg::WR_WRITE:   phase_lim = PW'(t_write);
      cfg_seq_pkg::WR_WHD:     phase_lim = PW'(t_whd);
      default:                 phase_lim = '0;
    endcase
  end

  assign phase_end = (phase_cnt == phase_lim);

  always_comb begin
    state_nxt = state;
    case (state)
      cfg_seq_pkg::WR_IDLE: begin
        if (bl_full && kickoff) begin
          state_nxt = cfg_seq_pkg::WR_WLCLK;
        end
      end
      cfg_seq_pkg::WR_WLCLK: begin
        // Move on once the single WL_CLK cycle is out
        if (wl_clk) begin
          state_nxt = cfg_seq_pkg::WR_SUBLWEN;
        end
      end
      cfg_seq_pkg::WR_SUBLWEN: begin
        if (phase_end) begin
          state_nxt = cfg_seq_pkg::WR_WSU;
        end
      end
      cfg_seq_pkg::WR_WSU: begin
        if (phase_end) begin
          state_nxt = cfg_seq_pkg::WR_WRITE;
        end
      end
      cfg_seq_pkg::WR_WRITE: begin
        if (phase_end) begin
          state_nxt = cfg_seq_pkg::WR_WHD;
        end
      end
      cfg_seq_pkg::WR_WHD: begin
        if (phase_end) begin
          state_nxt = cfg_seq_pkg::WR_IDLE;
        end
      end
      default: begin
        state_nxt = cfg_seq_pkg::WR_IDLE;
      end
    endcase
  end

  // Timer restarts at every phase change
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      state     <= cfg_seq_pkg::WR_IDLE;
      phase_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (phase_end) begin
        phase_cnt <= '0;
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
    end
  end

  // High for the second cycle of WR_WLCLK only
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      wl_clk <= 1'b0;
    end else begin
      wl_clk <= (state == cfg_seq_pkg::WR_WLCLK) && !wl_clk && kickoff;
    end
  end

  assign blwen = (state == cfg_seq_pkg::WR_WSU) || (state == cfg_seq_pkg::WR_WRITE) ||
                 (state == cfg_seq_pkg::WR_WHD);
  assign wlwen = (state == cfg_seq_pkg::WR_WRITE);

  // Last hold cycle
  assign write_done = (state == cfg_seq_pkg::WR_WHD) && phase_end && kickoff;

  assign line_start = (state == cfg_seq_pkg::WR_IDLE) && (state_nxt == cfg_seq_pkg::WR_WLCLK);

  // Head word rides along with the first wordline of a frame
  always_ff @(posedge FCB_CLK or negedge fcb_reg_rstn) begin
    if (!fcb_reg_rstn) begin
      ctrl_head <= '0;
    end else if (state == cfg_seq_pkg::WR_SUBLWEN) begin
      ctrl_head <= '0;
    end else if (line_start && wl_first && kickoff) begin
      ctrl_head <= wl_data_shift;
    end
  end

endmodule

//--- hw/cfg_ctrl_top.sv
`timescale 1ns/1ns

module cfg_ctrl_top #(
  parameter int CNT_W = 32
) (
  input  logic                              FCB_CLK,
  input  logic                              fcb_reg_rstn,
  input  logic                              apb_penable,
  input  logic                              apb_pwrite,
  input  logic [cfg_reg_pkg::ADDR_W-1:0]    apb_paddr,
  input  logic                              kickoff,
  input  cfg_reg_pkg::cfg_cmd_e             cmd,
  input  logic [CNT_W-1:0]                  bl_max_length,
  input  logic [CNT_W-1:0]                  wl_max_length,
  input  logic [cfg_reg_pkg::T_SUBL_W-1:0]  t_sublwen,
  input  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_wsu,
  input  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_write,
  input  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_whd,
  input  logic [31:0]                       wl_data_shift,
  output logic                              BL_CLK,
  output logic                              WL_CLK,
  output logic                              BLWEN,
  output logic                              WLWEN,
  output logic                              prechksum_w0,
  output logic                              prechksum_w1,
  output logic                              mask_write,
  output logic                              cfg_done,
  output logic [31:0]                       ctrl_head
);

  logic shift_wr;
  logic bl_full;
  logic wl_first;
  logic write_done;

  bl_shift_decode u_shift (
    .FCB_CLK      (FCB_CLK),
    .fcb_reg_rstn (fcb_reg_rstn),
    .apb_penable  (apb_penable),
    .apb_pwrite   (apb_pwrite),
    .apb_paddr    (apb_paddr),
    .kickoff      (kickoff),
    .mask_write   (mask_write),
    .shift_wr     (shift_wr),
    .bl_clk       (BL_CLK),
    .prechksum_w0 (prechksum_w0),
    .prechksum_w1 (prechksum_w1)
  );

  // Frame end is consumed inside the counter for done and wrap
  line_counter #(
    .CNT_W (CNT_W)
  ) u_lines (
    .FCB_CLK       (FCB_CLK),
    .fcb_reg_rstn  (fcb_reg_rstn),
    .shift_wr      (shift_wr),
    .apb_penable   (apb_penable),
    .kickoff       (kickoff),
    .wl_clk        (WL_CLK),
    .write_done    (write_done),
    .cmd           (cmd),
    .bl_max_length (bl_max_length),
    .wl_max_length (wl_max_length),
    .bl_full       (bl_full),
    .wl_last       (),
    .wl_first      (wl_first),
    .mask_write    (mask_write),
    .cfg_done      (cfg_done)
  );

  write_timing_fsm #(
    .CNT_W (CNT_W)
  ) u_wr_fsm (
    .FCB_CLK       (FCB_CLK),
    .fcb_reg_rstn  (fcb_reg_rstn),
    .kickoff       (kickoff),
    .bl_full       (bl_full),
    .wl_first      (wl_first),
    .t_sublwen     (t_sublwen),
    .t_wsu         (t_wsu),
    .t_write       (t_write),
    .t_whd         (t_whd),
    .wl_data_shift (wl_data_shift),
    .wl_clk        (WL_CLK),
    .blwen         (BLWEN),
    .wlwen         (WLWEN),
    .write_done    (write_done),
    .ctrl_head     (ctrl_head)
  );

endmodule

//--- bench/cfg_ctrl_assertions.sv
`timescale 1ns/1ns

module cfg_ctrl_assertions (
  input logic                           FCB_CLK,
  input logic                           fcb_reg_rstn,
  input logic                           apb_penable,
  input logic                           apb_pwrite,
  input logic [cfg_reg_pkg::ADDR_W-1:0] apb_paddr,
  input logic                           mask_write,
  input logic                           BL_CLK,
  input logic                           WL_CLK,
  input logic                           BLWEN,
  input logic                           WLWEN,
  input logic                           cfg_done
);

  int   fail_cnt = 0;
  logic masked_shift;

  // Shift write that arrives while the row is being committed
  assign masked_shift = apb_penable && apb_pwrite && mask_write &&
                        (apb_paddr == cfg_reg_pkg::BL_DATA_SHIFT_ADDR);

  wlwen_inside_blwen: assert property (@(posedge FCB_CLK) disable iff (!fcb_reg_rstn)
    WLWEN |-> BLWEN) else begin
    fail_cnt++;
    $error("WLWEN high while BLWEN is low");
  end

  wl_clk_single: assert property (@(posedge FCB_CLK) disable iff (!fcb_reg_rstn)
    WL_CLK |=> !WL_CLK) else begin
    fail_cnt++;
    $error("WL_CLK stayed high for two cycles");
  end

  done_in_hold: assert property (@(posedge FCB_CLK) disable iff (!fcb_reg_rstn)
    cfg_done |-> BLWEN) else begin
    fail_cnt++;
    $error("cfg_done high outside the write enable window");
  end

  masked_no_bl_clk: assert property (@(posedge FCB_CLK) disable iff (!fcb_reg_rstn)
    masked_shift |=> !BL_CLK) else begin
    fail_cnt++;
    $error("BL_CLK pulsed for a masked shift write");
  end

endmodule

//--- bench/cfg_ctrl_tb.sv
`timescale 1ns/1ns

module cfg_ctrl_tb;

  localparam int CNT_W        = 32;
  localparam int NUM_FRAMES   = 40;
  localparam int RST_CYCLES   = 16;
  // Four bitlines of at most four cycles plus the longest write of one line
  localparam int LINE_CYCLES  = 16 + 3 + 16;
  localparam int FRAME_CYCLES = 3 * LINE_CYCLES + 4;
  localparam int WATCHDOG_NS  = 2 * 20 * (RST_CYCLES + NUM_FRAMES * FRAME_CYCLES);

  // Model phases of one line write
  localparam int P_IDLE   = 0;
  localparam int P_WLWAIT = 1;
  localparam int P_WLCLK  = 2;
  localparam int P_SUBL   = 3;
  localparam int P_WSU    = 4;
  localparam int P_WRITE  = 5;
  localparam int P_WHD    = 6;

  logic                              FCB_CLK;
  logic                              fcb_reg_rstn;
  logic                              apb_penable;
  logic                              apb_pwrite;
  logic [cfg_reg_pkg::ADDR_W-1:0]    apb_paddr;
  logic                              kickoff;
  cfg_reg_pkg::cfg_cmd_e             cmd;
  logic [CNT_W-1:0]                  bl_max_length;
  logic [CNT_W-1:0]                  wl_max_length;
  logic [cfg_reg_pkg::T_SUBL_W-1:0]  t_sublwen;
  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_wsu;
  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_write;
  logic [cfg_reg_pkg::T_PHASE_W-1:0] t_whd;
  logic [31:0]                       wl_data_shift;
  logic                              BL_CLK;
  logic                              WL_CLK;
  logic                              BLWEN;
  logic                              WLWEN;
  logic                              prechksum_w0;
  logic                              prechksum_w1;
  logic                              mask_write;
  logic                              cfg_done;
  logic [31:0]                       ctrl_head;

  logic [31:0] lfsr;
  logic [31:0] m_bl_cnt;
  logic [31:0] m_wl_cnt;
  logic [31:0] m_head;
  logic        m_mask;
  logic        m_bl_clk;
  logic        m_w0;
  logic        m_w1;
  logic        m_frame_end;
  int          m_phase;
  int          m_left;
  int          idle_run;
  int          done_seen;
  int          wlclk_seen;
  int          check_cnt;
  int          err_cnt;
  int          assert_err_cnt;
  string       test_name;

  cfg_ctrl_top #(
    .CNT_W (CNT_W)
  ) u_dut (.*);

  bind cfg_ctrl_top cfg_ctrl_assertions u_assert (
    .FCB_CLK      (FCB_CLK),
    .fcb_reg_rstn (fcb_reg_rstn),
    .apb_penable  (apb_penable),
    .apb_pwrite   (apb_pwrite),
    .apb_paddr    (apb_paddr),
    .mask_write   (mask_write),
    .BL_CLK       (BL_CLK),
    .WL_CLK       (WL_CLK),
    .BLWEN        (BLWEN),
    .WLWEN        (WLWEN),
    .cfg_done     (cfg_done)
  );

  always #10 FCB_CLK = ~FCB_CLK;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic compare_bit(input string sig, input logic exp, input logic act);
    check_cnt++;
    assert (exp === act) else begin
      err_cnt++;
      $display("Error: %s %s expected %b actual %b at %0t", test_name, sig, exp, act, $time);
    end
  endtask

  task automatic compare_word(input string sig, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    assert (exp === act) else begin
      err_cnt++;
      $display("Error: %s %s expected %h actual %h at %0t", test_name, sig, exp, act, $time);
    end
  endtask

  task automatic check_outputs();
    logic wr_done;
    logic done_exp;
    wr_done  = (m_phase == P_WHD) && (m_left == 1) && kickoff;
    done_exp = wr_done && (m_bl_cnt == bl_max_length + 32'd1) &&
               (m_wl_cnt == wl_max_length + 32'd1) &&
               (cmd == cfg_reg_pkg::CMD_NONE || cmd == cfg_reg_pkg::CMD_PRE);
    compare_bit("BL_CLK", m_bl_clk, BL_CLK);
    compare_bit("WL_CLK", m_phase == P_WLCLK, WL_CLK);
    compare_bit("BLWEN", m_phase >= P_WSU, BLWEN);
    compare_bit("WLWEN", m_phase == P_WRITE, WLWEN);
    compare_bit("prechksum_w0", m_w0, prechksum_w0);
    compare_bit("prechksum_w1", m_w1, prechksum_w1);
    compare_bit("mask_write", m_mask, mask_write);
    compare_bit("cfg_done", done_exp, cfg_done);
    compare_word("ctrl_head", m_head, ctrl_head);
    done_seen  += int'(cfg_done === 1'b1);
    wlclk_seen += int'(WL_CLK === 1'b1);
  endtask

  // Next cycle of the reference model from the inputs now on the pins
  task automatic advance_model();
    logic shift;
    logic wr_done;
    logic bl_full;
    logic wl_last;
    shift   = apb_penable && apb_pwrite && !m_mask &&
              (apb_paddr == cfg_reg_pkg::BL_DATA_SHIFT_ADDR);
    wr_done = (m_phase == P_WHD) && (m_left == 1) && kickoff;
    bl_full = (m_bl_cnt == bl_max_length + 32'd1);
    wl_last = (m_wl_cnt == wl_max_length + 32'd1);
    m_frame_end = wr_done && wl_last;
    m_w1     = m_w0;
    m_w0     = shift;
    m_bl_clk = shift && kickoff;
    if (wr_done) begin
      m_mask = 1'b0;
    end else if ((m_bl_cnt == bl_max_length) && apb_penable && kickoff) begin
      m_mask = 1'b1;
    end
    if (m_phase == P_SUBL) begin
      m_head = '0;
    end else if (m_phase == P_IDLE && bl_full && kickoff && m_wl_cnt == 0) begin
      m_head = wl_data_shift;
    end
    if (wr_done) begin
      m_bl_cnt = '0;
    end else if (shift) begin
      m_bl_cnt = m_bl_cnt + 32'd1;
    end
    if (wr_done && wl_last) begin
      m_wl_cnt = '0;
    end else if (m_phase == P_WLCLK) begin
      m_wl_cnt = m_wl_cnt + 32'd1;
    end
    case (m_phase)
      P_IDLE: begin
        if (bl_full && kickoff) begin
          m_phase = P_WLWAIT;
        end
      end
      P_WLWAIT: begin
        if (kickoff) begin
          m_phase = P_WLCLK;
        end
      end
      P_WLCLK: begin
        m_phase = P_SUBL;
        m_left  = int'(t_sublwen) + 1;
      end
      default: begin
        if (m_left > 1) begin
          m_left--;
        end else begin
          m_phase = (m_phase == P_WHD) ? P_IDLE : m_phase + 1;
          m_left  = (m_phase == P_WSU) ? int'(t_wsu) + 1 :
                    (m_phase == P_WRITE) ? int'(t_write) + 1 : int'(t_whd) + 1;
        end
      end
    endcase
  endtask

  // Random bus cycle where the last bitline of a row only ever gets a shift or nothing
  task automatic drive_bus();
    logic [31:0] pick;
    logic [31:0] addr;
    pick = rand_bits(3);
    if (!m_mask && idle_run >= 3) begin
      pick = 32'd2;
    end
    if (!m_mask && (m_bl_cnt == bl_max_length) && pick >= 6) begin
      pick = 32'd0;
    end
    apb_penable = (pick >= 2);
    apb_pwrite  = (pick >= 2) && (pick <= 6);
    apb_paddr   = cfg_reg_pkg::BL_DATA_SHIFT_ADDR;
    if (pick == 6) begin
      addr = rand_bits(8);
      apb_paddr = (addr == cfg_reg_pkg::BL_DATA_SHIFT_ADDR) ? addr + 32'd1 : addr;
    end
    if (m_mask || (pick >= 2 && pick <= 5)) begin
      idle_run = 0;
    end else begin
      idle_run++;
    end
  endtask

  task automatic run_frame(input int idx);
    logic [1:0] cmd_bits;
    test_name = $sformatf("frame %0d", idx);
    @(negedge FCB_CLK);
    check_outputs();
    bl_max_length = rand_bits(2);
    wl_max_length = rand_bits(2) % 3;
    t_sublwen     = 3'(rand_bits(2));
    t_wsu         = 8'(rand_bits(2));
    t_write       = 8'(rand_bits(2));
    t_whd         = 8'(rand_bits(2));
    cmd_bits      = 2'(rand_bits(2));
    cmd           = cfg_reg_pkg::cfg_cmd_e'(cmd_bits);
    wl_data_shift = rand_bits(32);
    apb_penable   = 1'b0;
    apb_pwrite    = 1'b0;
    advance_model();
    done_seen  = 0;
    wlclk_seen = 0;
    idle_run   = 0;
    m_frame_end = 1'b0;
    while (!m_frame_end) begin
      @(negedge FCB_CLK);
      check_outputs();
      drive_bus();
      advance_model();
    end
    compare_word("WL_CLK pulses", wl_max_length + 32'd1, 32'(wlclk_seen));
    compare_word("cfg_done pulses", {31'd0, cmd_bits <= 2'd1}, 32'(done_seen));
  endtask

  initial begin
    lfsr          = 32'hf006d226;
    FCB_CLK       = 1'b0;
    fcb_reg_rstn  = 1'b0;
    apb_penable   = 1'b0;
    apb_pwrite    = 1'b0;
    apb_paddr     = '0;
    kickoff       = 1'b0;
    cmd           = cfg_reg_pkg::CMD_NONE;
    bl_max_length = '0;
    wl_max_length = '0;
    t_sublwen     = '0;
    t_wsu         = '0;
    t_write       = '0;
    t_whd         = '0;
    wl_data_shift = '0;
    m_bl_cnt      = '0;
    m_wl_cnt      = '0;
    m_head        = '0;
    m_mask        = 1'b0;
    m_bl_clk      = 1'b0;
    m_w0          = 1'b0;
    m_w1          = 1'b0;
    m_phase       = P_IDLE;
    m_left        = 0;
    check_cnt     = 0;
    err_cnt       = 0;
    test_name     = "reset";
    repeat (RST_CYCLES) @(posedge FCB_CLK);
    @(negedge FCB_CLK);
    check_outputs();
    fcb_reg_rstn = 1'b1;
    kickoff      = 1'b1;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      run_frame(f);
    end
    test_name = "drain";
    apb_penable = 1'b0;
    repeat (3) begin
      @(negedge FCB_CLK);
      check_outputs();
      advance_model();
    end
    assert_err_cnt = u_dut.u_assert.fail_cnt;
    $display("Summary: %0d checks, %0d value errors, %0d bound assertion errors",
             check_cnt, err_cnt, assert_err_cnt);
    if (err_cnt == 0 && assert_err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the frames did not complete", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- cfg_ctrl.f
hw/cfg_reg_pkg.sv
hw/cfg_seq_pkg.sv
hw/bl_shift_decode.sv
hw/line_counter.sv
hw/write_timing_fsm.sv
hw/cfg_ctrl_top.sv
bench/cfg_ctrl_assertions.sv
bench/cfg_ctrl_tb.sv

//--- Makefile
TOP := cfg_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f cfg_ctrl.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f cfg_ctrl.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
